// File: verilog/load_pkg.sv
// ---------------------------------------------------------------------
// load unit package
// widths, load operation encoding and cache transfer size shared by the
// request FSM, the result path and the top level
// ---------------------------------------------------------------------
package load_pkg;

    // ---------------------------------------------------------------------
    // widths
    // ---------------------------------------------------------------------

    // cache read data and load result
    localparam int unsigned DATA_W     = 64;
    // virtual address as seen by the load unit
    localparam int unsigned VADDR_W    = 32;
    // physical address returned by the data TLB
    localparam int unsigned PADDR_W    = 34;
    // the cache index comes from the untranslated page offset
    localparam int unsigned INDEX_W    = 12;
    // physical bits above the index form the tag
    localparam int unsigned TAG_W      = PADDR_W - INDEX_W;
    // scoreboard transaction id
    localparam int unsigned TRANS_ID_W = 3;
    // one enable per byte of the double word
    localparam int unsigned BE_W       = DATA_W / 8;
    // byte offset inside a double word
    localparam int unsigned OFFSET_W   = 3;

    // ---------------------------------------------------------------------
    // types
    // ---------------------------------------------------------------------

    // integer load operations, the U variants zero extend
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_t;

    // transfer size as the data cache expects it
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } load_size_t;

    // map a load operation to the number of bytes it moves
    function automatic load_size_t load_size_of(load_op_t op);
        load_size_t size;
        case (op)
            LW, LWU:  size = SIZE_WORD;
            LH, LHU:  size = SIZE_HALF;
            LB, LBU:  size = SIZE_BYTE;
            default:  size = SIZE_DOUBLE;
        endcase
        return size;
    endfunction

endpackage

// File: verilog/load_req_fsm.sv
// ---------------------------------------------------------------------
// load request FSM
// drives translation, the cache index/tag handshake, the page offset
// stall, TLB miss aborts and flushes, and qualifies the cache response
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module load_req_fsm (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    // request from the issue side
    input  logic                        valid_i,
    input  load_pkg::load_op_t          op_i,
    // data TLB answer, same cycle as translation_req_o
    input  logic [load_pkg::PADDR_W-1:0] paddr_i,
    input  logic                        dtlb_hit_i,
    // a pending store touches the same page offset
    input  logic                        page_offset_matches_i,
    // data cache handshake
    input  logic                        data_gnt_i,
    input  logic                        data_rvalid_i,
    output logic                        pop_o,
    output logic                        translation_req_o,
    output logic                        data_req_o,
    output logic                        tag_valid_o,
    output logic                        kill_req_o,
    output logic [load_pkg::TAG_W-1:0]  address_tag_o,
    output load_pkg::load_size_t        data_size_o,
    // qualified response
    output logic                        valid_o
);
    import load_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_t;

    state_t state_d, state_q;

    // physical tag held for the cycle after the grant
    logic [TAG_W-1:0] tag_q;

    // the transfer size only depends on the operation of the held request
    assign data_size_o = load_size_of(op_i);

    // ---------------------------------------------------------------------
    // request control
    // ---------------------------------------------------------------------
    always_comb begin : request_control
        state_d           = state_q;
        pop_o             = 1'b0;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;

        case (state_q)
            // SEND_TAG finishes the previous load and takes a new one in
            // the same cycle, so both share the accept path
            IDLE, SEND_TAG: begin
                if (state_q == SEND_TAG) begin
                    // the tag registered at grant goes out now
                    tag_valid_o = 1'b1;
                end
                state_d = IDLE;
                if (valid_i) begin
                    // translation starts right away, before the store check
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        // an older store to the same offset has to drain first
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        data_req_o = 1'b1;
                        if (!data_gnt_i) begin
                            state_d = WAIT_GNT;
                        end else if (dtlb_hit_i) begin
                            // granted and translated so the tag follows next cycle
                            state_d = SEND_TAG;
                            pop_o   = 1'b1;
                        end else begin
                            // granted without a translation, give the slot back
                            state_d = ABORT_TRANSACTION;
                        end
                    end
                end
            end

            // hold the index request and the translation until the grant
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
                if (data_gnt_i) begin
                    if (dtlb_hit_i) begin
                        state_d = SEND_TAG;
                        pop_o   = 1'b1;
                    end else begin
                        state_d = ABORT_TRANSACTION;
                    end
                end
            end

            // no cache request at all until the store conflict is gone
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // kill together with tag valid releases the granted request so
            // the page table walker can reach the cache
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            // keep asking the TLB and start over once it hits
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // cancel whatever may still be outstanding in the cache
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // a flush wins over every transition above
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // ---------------------------------------------------------------------
    // response qualification
    // ---------------------------------------------------------------------

    // data that shows up while the unit is killing a request belongs to
    // the cancelled load and is dropped
    assign valid_o = data_rvalid_i && (state_q != WAIT_FLUSH) && !kill_req_o;

    // the tag is sampled in the grant cycle and presented in the next one
    assign address_tag_o = tag_q;

    always_ff @(posedge clk_i) begin
        if (data_req_o && data_gnt_i) begin
            tag_q <= paddr_i[INDEX_W+TAG_W-1:INDEX_W];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: verilog/load_result_align.sv
// ---------------------------------------------------------------------
// load result path
// keeps the popped load's id, offset and operation and turns the raw
// cache double word into the aligned, extended load result
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module load_result_align (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // capture strobe, high in the cycle the request is taken
    input  logic                             pop_i,
    input  logic [load_pkg::VADDR_W-1:0]     vaddr_i,
    input  load_pkg::load_op_t               op_i,
    input  logic [load_pkg::TRANS_ID_W-1:0]  trans_id_i,
    // raw read data from the data cache
    input  logic [load_pkg::DATA_W-1:0]      data_rdata_i,
    output logic [load_pkg::TRANS_ID_W-1:0]  trans_id_o,
    output logic [load_pkg::DATA_W-1:0]      result_o
);
    import load_pkg::*;

    // ---------------------------------------------------------------------
    // pending load
    // ---------------------------------------------------------------------
    logic [TRANS_ID_W-1:0] trans_id_q;
    logic [OFFSET_W-1:0]   offset_q;
    load_op_t              op_q;
    logic                  signed_d, signed_q;
    logic [OFFSET_W-1:0]   sign_idx_d, sign_idx_q;

    // only the sign extending loads need a sign bit at all
    assign signed_d = op_i inside {LW, LH, LB};

    // the sign sits in the most significant byte of the loaded item, so
    // its byte lane is known as soon as the offset and the size are
    always_comb begin
        case (op_i)
            LW, LWU: sign_idx_d = vaddr_i[OFFSET_W-1:0] + 3'd3;
            LH, LHU: sign_idx_d = vaddr_i[OFFSET_W-1:0] + 3'd1;
            LB, LBU: sign_idx_d = vaddr_i[OFFSET_W-1:0];
            default: sign_idx_d = 3'd7;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            trans_id_q <= trans_id_i;
            offset_q   <= vaddr_i[OFFSET_W-1:0];
        end
    end

    // the fields that steer the result mux start from a known value
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q       <= LD;
            signed_q   <= 1'b0;
            sign_idx_q <= '0;
        end else if (pop_i) begin
            op_q       <= op_i;
            signed_q   <= signed_d;
            sign_idx_q <= sign_idx_d;
        end
    end

    assign trans_id_o = trans_id_q;

    // ---------------------------------------------------------------------
    // realign and extend
    // ---------------------------------------------------------------------
    logic [DATA_W-1:0] shifted_data;
    logic [BE_W-1:0]   sign_bits;
    logic              sign_bit;

    // move the addressed byte down to bit zero
    assign shifted_data = data_rdata_i >> {offset_q, 3'b000};

    // top bit of every byte lane
    always_comb begin
        for (int i = 0; i < BE_W; i++) begin
            sign_bits[i] = data_rdata_i[8*i+7];
        end
    end

    // the sign select runs beside the shifter instead of after it
    // and an unsigned load pulls it to zero
    assign sign_bit = signed_q & sign_bits[sign_idx_q];

    always_comb begin
        case (op_q)
            LW, LWU: result_o = {{(DATA_W-32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(DATA_W-16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(DATA_W-8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

endmodule

// File: verilog/load_unit.sv
// ---------------------------------------------------------------------
// load unit
// one load at a time from issue to the data cache and back, with the
// request FSM on one side and the result alignment on the other
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module load_unit (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    // issue side, held stable until pop_o
    input  logic                             valid_i,
    input  logic [load_pkg::VADDR_W-1:0]     vaddr_i,
    input  load_pkg::load_op_t               op_i,
    input  logic [load_pkg::BE_W-1:0]        be_i,
    input  logic [load_pkg::TRANS_ID_W-1:0]  trans_id_i,
    output logic                             pop_o,
    // address translation
    output logic                             translation_req_o,
    input  logic [load_pkg::PADDR_W-1:0]     paddr_i,
    input  logic                             dtlb_hit_i,
    // store address check
    input  logic                             page_offset_matches_i,
    output logic [load_pkg::INDEX_W-1:0]     page_offset_o,
    // data cache request
    output logic                             data_req_o,
    input  logic                             data_gnt_i,
    output logic [load_pkg::INDEX_W-1:0]     address_index_o,
    output logic [load_pkg::TAG_W-1:0]       address_tag_o,
    output logic                             tag_valid_o,
    output logic                             kill_req_o,
    output logic [load_pkg::BE_W-1:0]        data_be_o,
    output load_pkg::load_size_t             data_size_o,
    // data cache response
    input  logic                             data_rvalid_i,
    input  logic [load_pkg::DATA_W-1:0]      data_rdata_i,
    // result to the scoreboard
    output logic                             valid_o,
    output logic [load_pkg::TRANS_ID_W-1:0]  trans_id_o,
    output logic [load_pkg::DATA_W-1:0]      result_o
);
    import load_pkg::*;

    // ---------------------------------------------------------------------
    // address split
    // ---------------------------------------------------------------------

    // the cache is virtually indexed, so index and page offset are the
    // same untranslated low bits
    assign address_index_o = vaddr_i[INDEX_W-1:0];
    assign page_offset_o   = vaddr_i[INDEX_W-1:0];

    // loads read whatever lanes the issuer enabled
    assign data_be_o = be_i;

    // ---------------------------------------------------------------------
    // request control and result path
    // ---------------------------------------------------------------------
    load_req_fsm u_req_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .op_i                  (op_i),
        .paddr_i               (paddr_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .data_gnt_i            (data_gnt_i),
        .data_rvalid_i         (data_rvalid_i),
        .pop_o                 (pop_o),
        .translation_req_o     (translation_req_o),
        .data_req_o            (data_req_o),
        .tag_valid_o           (tag_valid_o),
        .kill_req_o            (kill_req_o),
        .address_tag_o         (address_tag_o),
        .data_size_o           (data_size_o),
        .valid_o               (valid_o)
    );

    // the pending load is captured with the same pop the issuer sees
    load_result_align u_result_align (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pop_i        (pop_o),
        .vaddr_i      (vaddr_i),
        .op_i         (op_i),
        .trans_id_i   (trans_id_i),
        .data_rdata_i (data_rdata_i),
        .trans_id_o   (trans_id_o),
        .result_o     (result_o)
    );

endmodule

// File: tb/dcache_tlb_model.sv
// ---------------------------------------------------------------------
// data cache and TLB responder for the load unit testbench
// random TLB hits, grant delay and store conflicts, with read data
// taken from a hash of the physical double word address
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module dcache_tlb_model (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         valid_i,
    input  logic                         pop_i,
    input  logic [load_pkg::VADDR_W-1:0] vaddr_i,
    input  logic                         data_req_i,
    output logic [load_pkg::PADDR_W-1:0] paddr_o,
    output logic                         dtlb_hit_o,
    output logic                         page_offset_matches_o,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output logic [load_pkg::DATA_W-1:0]  data_rdata_o
);
    import load_pkg::*;

    integer             seed;
    // cycles the current request has waited, and how long it has to wait
    int unsigned        gnt_wait_q;
    int unsigned        gnt_delay_q;
    // remaining cycles of the store conflict for the next load
    int unsigned        conflict_q;
    logic               rsp_pending_q;
    logic [PADDR_W-4:0] rsp_dword_q;

    // multiplicative hash, so neighbouring double words differ in every lane
    function automatic logic [DATA_W-1:0] dword_hash(input logic [PADDR_W-4:0] dword);
        logic [DATA_W-1:0] h;
        h = DATA_W'(dword) * 64'h9e37_79b9_7f4a_7c15;
        return h ^ (h >> 31);
    endfunction

    // every page maps one step above the 4 GiB boundary
    assign paddr_o = PADDR_W'(vaddr_i) + 34'h1_0000_0000;

    initial begin
        seed                  = 23;
        dtlb_hit_o            = 1'b0;
        page_offset_matches_o = 1'b0;
        data_gnt_o            = 1'b0;
        data_rvalid_o         = 1'b0;
        data_rdata_o          = '0;
    end

    // ---------------------------------------------------------------------
    // bookkeeping on the rising edge, where the unit's outputs are settled
    // ---------------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_wait_q    <= 0;
            gnt_delay_q   <= 0;
            conflict_q    <= 0;
            rsp_pending_q <= 1'b0;
            rsp_dword_q   <= '0;
        end else begin
            // only a translated grant is answered in the following tag cycle
            rsp_pending_q <= data_req_i && data_gnt_o && dtlb_hit_o;
            if (data_req_i && data_gnt_o) begin
                rsp_dword_q <= paddr_o[PADDR_W-1:3];
                gnt_wait_q  <= 0;
                gnt_delay_q <= $unsigned($random(seed)) % 3;
            end else if (data_req_i) begin
                gnt_wait_q <= gnt_wait_q + 1;
            end
            // about one load in four meets an older store to its offset
            if (pop_i) begin
                conflict_q <= (($random(seed) & 3) == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
            end else if (valid_i && conflict_q != 0) begin
                conflict_q <= conflict_q - 1;
            end
        end
    end

    // answers go out on the falling edge
    always @(negedge clk_i) begin
        dtlb_hit_o            <= ($random(seed) & 3) != 0;
        data_gnt_o            <= gnt_wait_q >= gnt_delay_q;
        page_offset_matches_o <= conflict_q != 0;
        // the data is already on its way when a flush kill meets the tag cycle
        data_rvalid_o         <= rsp_pending_q;
        data_rdata_o          <= dword_hash(rsp_dword_q);
    end

endmodule

// File: tb/load_unit_tb.sv
// ---------------------------------------------------------------------
// load unit testbench
// random loads against a cache and TLB model, checked cycle by cycle
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module load_unit_tb;
    import load_pkg::*;

    localparam int NUM_LOADS      = 200;
    localparam int TIMEOUT_CYCLES = 60 * NUM_LOADS;

    logic                  clk_i, rst_ni, flush_i, valid_i;
    logic [VADDR_W-1:0]    vaddr_i;
    load_op_t              op_i;
    logic [BE_W-1:0]       be_i, data_be_o;
    logic [TRANS_ID_W-1:0] trans_id_i, trans_id_o;
    logic                  pop_o, translation_req_o, dtlb_hit_i, page_offset_matches_i;
    logic [PADDR_W-1:0]    paddr_i;
    logic [INDEX_W-1:0]    page_offset_o, address_index_o;
    logic [TAG_W-1:0]      address_tag_o, exp_tag_q;
    logic                  data_req_o, data_gnt_i, tag_valid_o, kill_req_o;
    load_size_t            data_size_o;
    logic                  data_rvalid_i, valid_o;
    logic [DATA_W-1:0]     data_rdata_i, result_o;

    // results still owed by the unit, oldest first
    logic [DATA_W-1:0]     exp_result_q[$];
    logic [TRANS_ID_W-1:0] exp_id_q[$];
    // what happened in the previous cycle
    logic                  gnt_hit_q, gnt_miss_q, flush_q, req_wait_q, seen_valid_q;
    logic [INDEX_W-1:0]    index_q;
    integer                seed;
    int                    cycle_count;

    load_unit dut_i (.*);

    dcache_tlb_model model_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .pop_i                 (pop_o),
        .vaddr_i               (vaddr_i),
        .data_req_i            (data_req_o),
        .paddr_o               (paddr_i),
        .dtlb_hit_o            (dtlb_hit_i),
        .page_offset_matches_o (page_offset_matches_i),
        .data_gnt_o            (data_gnt_i),
        .data_rvalid_o         (data_rvalid_i),
        .data_rdata_o          (data_rdata_i)
    );

    always #20 clk_i = ~clk_i;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [DATA_W-1:0] actual,
                                input logic [DATA_W-1:0] expected);
        assert (actual === expected)
        else report_failure($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic logic [DATA_W-1:0] dword_hash(input logic [PADDR_W-4:0] dword);
        logic [DATA_W-1:0] h;
        h = DATA_W'(dword) * 64'h9e37_79b9_7f4a_7c15;
        return h ^ (h >> 31);
    endfunction

    // the loaded item sits at the byte offset and is extended to 64 bits
    function automatic logic [DATA_W-1:0] expected_result(input logic [VADDR_W-1:0] vaddr,
                                                          input load_op_t op);
        logic [PADDR_W-1:0] paddr;
        logic [DATA_W-1:0]  item;
        paddr = PADDR_W'(vaddr) + 34'h1_0000_0000;
        item  = dword_hash(paddr[PADDR_W-1:3]) >> (8 * vaddr[2:0]);
        case (op)
            LW:      item = {{32{item[31]}}, item[31:0]};
            LWU:     item = {32'd0, item[31:0]};
            LH:      item = {{48{item[15]}}, item[15:0]};
            LHU:     item = {48'd0, item[15:0]};
            LB:      item = {{56{item[7]}}, item[7:0]};
            LBU:     item = {56'd0, item[7:0]};
            default: ;
        endcase
        return item;
    endfunction

    // cache size code by the number of bytes a load moves
    function automatic logic [1:0] expected_size(input load_op_t op);
        logic [1:0] code;
        case (op)
            LB, LBU: code = 2'd0;
            LH, LHU: code = 2'd1;
            LW, LWU: code = 2'd2;
            default: code = 2'd3;
        endcase
        return code;
    endfunction

    // hold one load until it is popped, a flush now and then drops it
    task automatic present_load(input logic [VADDR_W-1:0] vaddr, input load_op_t op,
                                input logic [BE_W-1:0] be, input logic [TRANS_ID_W-1:0] id);
        logic taken;
        taken      = 1'b0;
        valid_i    = 1'b1;
        vaddr_i    = vaddr;
        op_i       = op;
        be_i       = be;
        trans_id_i = id;
        while (!taken) begin
            flush_i = ($unsigned($random(seed)) % 64) == 0;
            @(posedge clk_i);
            taken = pop_o || flush_i;
            @(negedge clk_i);
            flush_i = 1'b0;
        end
        valid_i = 1'b0;
    endtask

    // ---------------------------------------------------------------------
    // checks, sampled on the rising edge
    // ---------------------------------------------------------------------
    always @(posedge clk_i) begin : check_outputs
        if (rst_ni) begin
            if (!seen_valid_q && !valid_i) begin
                expect_equal("pop_o/data_req_o/translation_req_o/tag_valid_o/kill_req_o/valid_o",
                             {pop_o, data_req_o, translation_req_o, tag_valid_o, kill_req_o,
                              valid_o}, 0);
            end
            // tag cycle after every grant, with kill after a miss or a flush
            expect_equal("tag_valid_o", tag_valid_o, gnt_hit_q || gnt_miss_q || flush_q);
            expect_equal("kill_req_o", kill_req_o, gnt_miss_q || flush_q);
            if (gnt_hit_q) expect_equal("address_tag_o", address_tag_o, exp_tag_q);
            if (kill_req_o) expect_equal("valid_o", valid_o, 0);
            if (req_wait_q) begin
                expect_equal("data_req_o/translation_req_o/address_index_o",
                             {data_req_o, translation_req_o, address_index_o}, {2'b11, index_q});
            end
            if (page_offset_matches_i) expect_equal("data_req_o", data_req_o, 0);
            expect_equal("data_be_o", data_be_o, be_i);
            expect_equal("page_offset_o", page_offset_o, vaddr_i[INDEX_W-1:0]);
            expect_equal("data_size_o", data_size_o, expected_size(op_i));
            if (data_req_o) begin
                expect_equal("address_index_o", address_index_o, vaddr_i[INDEX_W-1:0]);
            end
            if (valid_o) begin
                if (exp_result_q.size() == 0) report_failure("valid_o without an outstanding load");
                expect_equal("result_o", result_o, exp_result_q.pop_front());
                expect_equal("trans_id_o", trans_id_o, exp_id_q.pop_front());
            end
            // a load popped in the flush cycle is cancelled
            if (pop_o && !flush_i) begin
                exp_result_q.push_back(expected_result(vaddr_i, op_i));
                exp_id_q.push_back(trans_id_i);
            end
        end
        seen_valid_q <= rst_ni && (seen_valid_q || valid_i);
        gnt_hit_q    <= data_req_o && data_gnt_i && dtlb_hit_i;
        gnt_miss_q   <= data_req_o && data_gnt_i && !dtlb_hit_i;
        flush_q      <= flush_i;
        req_wait_q   <= data_req_o && !data_gnt_i && !flush_i;
        exp_tag_q    <= paddr_i[PADDR_W-1:INDEX_W];
        index_q      <= vaddr_i[INDEX_W-1:0];
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) report_failure("timeout, the loads never finished");
    end

    initial begin : stimulus
        logic [VADDR_W-1:0] vaddr;
        load_op_t           op;
        int unsigned        nbytes;
        int                 n;
        seed       = 23;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        vaddr_i    = '0;
        op_i       = LD;
        be_i       = '0;
        trans_id_i = '0;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (3) @(negedge clk_i);
        for (n = 0; n < NUM_LOADS; n++) begin
            // the first 56 loads sweep every operation over every offset
            op    = (n < 56) ? load_op_t'(n / 8) : load_op_t'($unsigned($random(seed)) % 7);
            vaddr = $random(seed);
            if (n < 56) vaddr[2:0] = 3'(n % 8);
            nbytes     = 1 << load_size_of(op);
            vaddr[2:0] = vaddr[2:0] & 3'(~(nbytes - 1));
            present_load(vaddr, op, BE_W'(((1 << nbytes) - 1) << vaddr[2:0]), n[2:0]);
            repeat ($unsigned($random(seed)) % 3) @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        if (exp_result_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure("some loads never returned a result");
        end
    end

endmodule

// File: vlog.f
verilog/load_pkg.sv
verilog/load_req_fsm.sv
verilog/load_result_align.sv
verilog/load_unit.sv
tb/dcache_tlb_model.sv
tb/load_unit_tb.sv
